// ==== design/soc_defines.svh ====
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

`define SOC_MEM_WORDS 1024         // Memory depth in words, index from low address bits

`define SOC_UART_BIT_CLOCKS 8      // Clocks per UART bit

`define SOC_UART_TAG 16'h8000      // addr[29:14] of UART region
`define SOC_DEBUG_TAG 16'h8001     // addr[29:14] of debug latch region

`endif

// ==== design/soc_pkg.sv ====
package soc_pkg;

	typedef logic [31:0] word_t;     // Bus data word
	typedef logic [29:0] addr_t;     // Word address
	typedef logic [7:0] byte_t;      // UART character
	typedef logic [6:0] seg_t;       // Segments g..a, active low

	// Target of a bus access
	typedef enum logic [1:0] {
		region_mem,                  // addr[29] == 0
		region_uart,                 // UART tag
		region_debug,                // Debug latch tag
		region_none                  // Unmapped
	} region_t;

endpackage

// ==== design/cpu_bus_if.sv ====
`timescale 1ns/1ps

interface cpu_bus_if;
	import soc_pkg::*;

	logic re;                        // Read strobe, one cycle
	logic we;                        // Write strobe, one cycle
	addr_t addr;                     // Word address
	word_t wdata;                    // Write data
	word_t rdata;                    // Read data, valid cycle after re

	// Drives the access, takes read data back
	modport master (
		output re,
		output we,
		output addr,
		output wdata,
		input rdata
	);

	// Answers the access
	modport slave (
		input re,
		input we,
		input addr,
		input wdata,
		output rdata
	);

endinterface

// ==== design/bus_decoder.sv ====
`timescale 1ns/1ps
`include "soc_defines.svh"

module bus_decoder (
	input logic CLOCK_24,
	input logic write_sync,
	cpu_bus_if.slave cpu,            // Upstream, from processor side
	cpu_bus_if.master mem,           // Toward memory
	cpu_bus_if.master uart,          // Toward UART
	output logic debug_we,
	output soc_pkg::word_t debug_data,
	output logic mem_re,
	output logic mem_we
);
	import soc_pkg::*;

	logic [15:0] tag;                // Upper address bits of peripheral space
	region_t region;                 // Region of current access
	region_t rd_region;              // Region of last read, selects rdata

	assign tag = cpu.addr[29:14];

	always_comb begin
		if (!cpu.addr[29]) begin
			region = region_mem;     // Whole lower half is memory
		end else if (tag == `SOC_UART_TAG) begin
			region = region_uart;
		end else if (tag == `SOC_DEBUG_TAG) begin
			region = region_debug;
		end else begin
			region = region_none;
		end
	end

	// Strobes reach the matching target only
	assign mem_re = cpu.re && (region == region_mem);
	assign mem_we = cpu.we && (region == region_mem);
	assign mem.re = mem_re;
	assign mem.we = mem_we;
	assign mem.addr = cpu.addr;
	assign mem.wdata = cpu.wdata;

	assign uart.re = cpu.re && (region == region_uart);
	assign uart.we = cpu.we && (region == region_uart);
	assign uart.addr = cpu.addr;
	assign uart.wdata = cpu.wdata;

	assign debug_we = cpu.we && (region == region_debug);   // Write only, reads give zero
	assign debug_data = cpu.wdata;

	// Remember where the read went, data comes back next cycle
	always_ff @(posedge CLOCK_24 or posedge write_sync) begin
		if (write_sync) begin
			rd_region <= region_none;   // rdata reads zero out of reset
		end else if (cpu.re) begin
			rd_region <= region;
		end
	end

	always_comb begin
		case (rd_region)
			region_mem: cpu.rdata = mem.rdata;
			region_uart: cpu.rdata = uart.rdata;
			default: cpu.rdata = '0;    // Debug and unmapped
		endcase
	end

	// Processor never issues read and write in the same cycle
	a_no_rw_overlap: assert property (@(posedge CLOCK_24) disable iff (write_sync)
		!(cpu.re && cpu.we))
		else $error("bus_decoder: re and we high together");

endmodule

// ==== design/sync_memory.sv ====
`timescale 1ns/1ps
`include "soc_defines.svh"

module sync_memory (
	input logic CLOCK_24,
	cpu_bus_if.slave bus
);
	import soc_pkg::*;

	localparam int WORDS = `SOC_MEM_WORDS;
	localparam int IDX_W = $clog2(WORDS);

	word_t mem_array [WORDS];        // Word storage
	logic [IDX_W-1:0] idx;           // Word index

	assign idx = bus.addr[IDX_W-1:0];   // Low bits only, upper bits alias

	always_ff @(posedge CLOCK_24) begin
		if (bus.we) begin
			mem_array[idx] <= bus.wdata;
		end
		if (bus.re) begin
			bus.rdata <= mem_array[idx];   // One cycle read latency
		end
	end

	// Index must be a known word whenever the memory is accessed
	a_idx_range: assert property (@(posedge CLOCK_24)
		(bus.re || bus.we) |-> !$isunknown(idx))
		else $error("sync_memory: access with unknown index");

endmodule

// ==== design/uart_port.sv ====
`timescale 1ns/1ps
`include "soc_defines.svh"

module uart_port (
	input logic CLOCK_24,
	input logic write_sync,
	cpu_bus_if.slave bus,
	input logic UART_RXD,
	output logic UART_TXD,
	output logic tx_busy
);
	import soc_pkg::*;

	localparam int BIT_CLKS = `SOC_UART_BIT_CLOCKS;
	localparam int CNT_W = $clog2(BIT_CLKS + 1);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(BIT_CLKS - 1);
	localparam logic [CNT_W-1:0] BIT_MID = CNT_W'(BIT_CLKS / 2 - 2);  // Minus sync delay

	logic [9:0] tx_shift;            // Stop, data, start; LSB on the line
	logic [CNT_W-1:0] tx_clk_cnt;    // Clocks within bit
	logic [3:0] tx_bit_cnt;          // 0 start .. 9 stop
	logic tx_start;                  // Accepted data write

	logic [1:0] rx_sync;             // Two-flop synchronizer
	logic rx_last;                   // Previous synced level, edge detect
	logic rx_active;                 // Frame in progress
	logic [CNT_W-1:0] rx_clk_cnt;
	logic [3:0] rx_bit_cnt;          // 0 start .. 9 stop
	logic [7:0] rx_shift;            // LSB first assembly
	byte_t rx_data;                  // Last received byte
	logic rx_valid;
	logic rx_sample;                 // Mid-bit strobe
	logic rx_read;                   // Data register read

	assign tx_start = bus.we && !bus.addr[0] && !tx_busy;   // Write while busy dropped
	assign UART_TXD = tx_shift[0];   // Idle ones shifted in behind stop bit

	always_ff @(posedge CLOCK_24 or posedge write_sync) begin
		if (write_sync) begin
			tx_busy <= 1'b0;
			tx_shift <= '1;          // Line idles high
			tx_clk_cnt <= '0;
			tx_bit_cnt <= '0;
		end else if (tx_start) begin
			tx_busy <= 1'b1;
			tx_shift <= {1'b1, bus.wdata[7:0], 1'b0};
			tx_clk_cnt <= '0;
			tx_bit_cnt <= '0;
		end else if (tx_busy) begin
			if (tx_clk_cnt == BIT_LAST) begin
				tx_clk_cnt <= '0;
				tx_shift <= {1'b1, tx_shift[9:1]};
				tx_bit_cnt <= tx_bit_cnt + 4'd1;
				if (tx_bit_cnt == 4'd9) begin
					tx_busy <= 1'b0;     // End of stop bit
				end
			end else begin
				tx_clk_cnt <= tx_clk_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge CLOCK_24 or posedge write_sync) begin
		if (write_sync) begin
			rx_sync <= 2'b11;
			rx_last <= 1'b1;
		end else begin
			rx_sync <= {rx_sync[0], UART_RXD};
			rx_last <= rx_sync[1];
		end
	end

	assign rx_sample = rx_active && (rx_clk_cnt == BIT_MID);
	assign rx_read = bus.re && !bus.addr[0];

	always_ff @(posedge CLOCK_24 or posedge write_sync) begin
		if (write_sync) begin
			rx_active <= 1'b0;
			rx_clk_cnt <= '0;
			rx_bit_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			if (rx_read) begin
				rx_valid <= 1'b0;    // New byte below wins over clear
			end
			if (!rx_active) begin
				if (rx_last && !rx_sync[1]) begin
					rx_active <= 1'b1;   // Falling edge, start bit
					rx_clk_cnt <= '0;
					rx_bit_cnt <= '0;
				end
			end else begin
				if (rx_clk_cnt == BIT_LAST) begin
					rx_clk_cnt <= '0;
					rx_bit_cnt <= rx_bit_cnt + 4'd1;
				end else begin
					rx_clk_cnt <= rx_clk_cnt + 1'b1;
				end
				if (rx_sample && (rx_bit_cnt == 4'd0) && rx_sync[1]) begin
					rx_active <= 1'b0;   // Glitch, not a start bit
				end else if (rx_sample && (rx_bit_cnt == 4'd9)) begin
					rx_active <= 1'b0;   // Stop bit, rearm for next edge
					rx_valid <= 1'b1;    // Overwrites unread byte
				end
			end
		end
	end

	always_ff @(posedge CLOCK_24) begin
		if (rx_sample && (rx_bit_cnt >= 4'd1) && (rx_bit_cnt <= 4'd8)) begin
			rx_shift <= {rx_sync[1], rx_shift[7:1]};
		end else if (rx_sample && (rx_bit_cnt == 4'd9)) begin
			rx_data <= rx_shift;
		end
	end

	// Register read, 0 data, 1 status
	always_ff @(posedge CLOCK_24) begin
		if (bus.re) begin
			if (bus.addr[0]) begin
				bus.rdata <= {30'd0, rx_valid, tx_busy};
			end else begin
				bus.rdata <= {24'd0, rx_data};
			end
		end
	end

	// Line only leaves idle while a frame is being sent
	a_txd_idle: assert property (@(posedge CLOCK_24) disable iff (write_sync)
		!tx_busy |-> UART_TXD)
		else $error("uart_port: UART_TXD low while transmitter idle");

endmodule

// ==== design/debug_display.sv ====
`timescale 1ns/1ps

module debug_display (
	input logic CLOCK_24,
	input logic write_sync,
	input logic debug_we,
	input soc_pkg::word_t debug_data,
	input logic [9:0] SW,
	input soc_pkg::addr_t addr,
	input soc_pkg::word_t rdata,
	output soc_pkg::seg_t HEX0,
	output soc_pkg::seg_t HEX1,
	output soc_pkg::seg_t HEX2,
	output soc_pkg::seg_t HEX3
);
	import soc_pkg::*;

	word_t debug_latch;              // Software debug word
	logic [15:0] view;               // Four nibbles on display

	// Nibble to segments g..a, active low
	function automatic seg_t hex_to_seg(input logic [3:0] nibble);
		case (nibble)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'ha: return 7'b0001000;
			4'hb: return 7'b0000011;   // Lower case b
			4'hc: return 7'b1000110;
			4'hd: return 7'b0100001;   // Lower case d
			4'he: return 7'b0000110;
			default: return 7'b0001110;   // F
		endcase
	endfunction

	always_ff @(posedge CLOCK_24 or posedge write_sync) begin
		if (write_sync) begin
			debug_latch <= '0;
		end else if (debug_we) begin
			debug_latch <= debug_data;
		end
	end

	// Switch priority SW9, SW8, SW7, SW1, SW0; SW[6:2] spare
	always_comb begin
		if (SW[9]) begin
			view = rdata[31:16];
		end else if (SW[8]) begin
			view = rdata[15:0];
		end else if (SW[7]) begin
			view = {2'b00, addr[29:16]};   // Only 14 upper address bits
		end else if (SW[1]) begin
			view = debug_latch[31:16];
		end else if (SW[0]) begin
			view = debug_latch[15:0];
		end else begin
			view = addr[15:0];
		end
	end

	assign HEX0 = hex_to_seg(view[3:0]);     // Rightmost digit
	assign HEX1 = hex_to_seg(view[7:4]);
	assign HEX2 = hex_to_seg(view[11:8]);
	assign HEX3 = hex_to_seg(view[15:12]);

endmodule

// ==== design/soc_top.sv ====
`timescale 1ns/1ps

module soc_top (
	input logic CLOCK_24,
	input logic write_sync,
	input logic mem_re,              // Processor read strobe
	input logic mem_we,              // Processor write strobe
	input soc_pkg::addr_t memaddr,
	input soc_pkg::word_t wmemdata,
	output soc_pkg::word_t rmemdata,
	input logic [9:0] SW,
	input logic UART_RXD,
	output logic UART_TXD,
	output soc_pkg::seg_t HEX0,
	output soc_pkg::seg_t HEX1,
	output soc_pkg::seg_t HEX2,
	output soc_pkg::seg_t HEX3,
	output logic [3:0] LEDG
);
	import soc_pkg::*;

	cpu_bus_if cpu_bus ();           // Processor side
	cpu_bus_if mem_bus ();           // Decoder to memory
	cpu_bus_if uart_bus ();          // Decoder to UART

	logic debug_we;
	word_t debug_data;
	logic mem_rd_hit;                // Gated memory read, for LED
	logic mem_wr_hit;                // Gated memory write, for LED
	logic tx_busy;

	assign cpu_bus.re = mem_re;
	assign cpu_bus.we = mem_we;
	assign cpu_bus.addr = memaddr;
	assign cpu_bus.wdata = wmemdata;
	assign rmemdata = cpu_bus.rdata;

	bus_decoder u_decoder (
		.CLOCK_24(CLOCK_24),
		.write_sync(write_sync),
		.cpu(cpu_bus.slave),
		.mem(mem_bus.master),
		.uart(uart_bus.master),
		.debug_we(debug_we),
		.debug_data(debug_data),
		.mem_re(mem_rd_hit),
		.mem_we(mem_wr_hit)
	);

	sync_memory u_mem (
		.CLOCK_24(CLOCK_24),
		.bus(mem_bus.slave)
	);

	uart_port u_uart (
		.CLOCK_24(CLOCK_24),
		.write_sync(write_sync),
		.bus(uart_bus.slave),
		.UART_RXD(UART_RXD),
		.UART_TXD(UART_TXD),
		.tx_busy(tx_busy)
	);

	debug_display u_display (
		.CLOCK_24(CLOCK_24),
		.write_sync(write_sync),
		.debug_we(debug_we),
		.debug_data(debug_data),
		.SW(SW),
		.addr(memaddr),              // Raw processor address
		.rdata(rmemdata),
		.HEX0(HEX0),
		.HEX1(HEX1),
		.HEX2(HEX2),
		.HEX3(HEX3)
	);

	assign LEDG = {tx_busy, mem_wr_hit, mem_rd_hit, write_sync};   // 3 busy, 2 wr, 1 rd, 0 rst

endmodule

// ==== testbench/tb_soc.sv ====
`timescale 1ns/1ps
`include "soc_defines.svh"

module tb_soc;
	import soc_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;              // Inputs change after the edge
	localparam int RESET_CYCLES = 16;
	localparam int MEM_OPS = 32;
	localparam int BIT_CLKS = `SOC_UART_BIT_CLOCKS;
	localparam int FRAME_CYCLES = 10 * BIT_CLKS;
	localparam int IDX_W = $clog2(`SOC_MEM_WORDS);
	localparam int TEST_CYCLES = RESET_CYCLES + 3 * MEM_OPS + 40 + 5 * FRAME_CYCLES;
	localparam addr_t UART_DATA = {`SOC_UART_TAG, 14'd0};
	localparam addr_t UART_STAT = {`SOC_UART_TAG, 14'd1};
	localparam addr_t DEBUG_ADDR = {`SOC_DEBUG_TAG, 14'd0};
	localparam addr_t UNMAPPED = {16'hC000, 14'd5};   // Outside every tag

	logic CLOCK_24, write_sync, mem_re, mem_we, UART_RXD, UART_TXD;
	addr_t memaddr;
	word_t wmemdata, rmemdata;
	logic [9:0] SW;
	seg_t HEX0, HEX1, HEX2, HEX3;
	logic [3:0] LEDG;

	logic [31:0] lcg_state;
	word_t shadow [`SOC_MEM_WORDS];              // Memory model
	addr_t written [$];                          // Addresses holding known data
	word_t exp_q [$];                            // Expected read data, in issue order
	string name_q [$];
	logic read_seen = 1'b0;                      // Read strobe taken last edge
	logic [9:0] sw_list [11] = '{10'h200, 10'h100, 10'h080, 10'h002, 10'h001, 10'h000,
		10'h3ff, 10'h183, 10'h083, 10'h003, 10'h07c};

	soc_top UUT (
		.CLOCK_24(CLOCK_24), .write_sync(write_sync),
		.mem_re(mem_re), .mem_we(mem_we), .memaddr(memaddr),
		.wmemdata(wmemdata), .rmemdata(rmemdata), .SW(SW),
		.UART_RXD(UART_RXD), .UART_TXD(UART_TXD),
		.HEX0(HEX0), .HEX1(HEX1), .HEX2(HEX2), .HEX3(HEX3), .LEDG(LEDG)
	);

	initial begin
		CLOCK_24 = 1'b0;
		forever #(CLK_PERIOD / 2) CLOCK_24 = ~CLOCK_24;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Standard digit shapes, bit 0 = segment a, lit = 1
	function automatic seg_t expected_seg(input logic [3:0] nibble);
		logic [6:0] lit;
		case (nibble)
			4'h0: lit = 7'h3f;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5b;
			4'h3: lit = 7'h4f;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6d;
			4'h6: lit = 7'h7d;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7f;
			4'h9: lit = 7'h6f;
			4'ha: lit = 7'h77;
			4'hb: lit = 7'h7c;
			4'hc: lit = 7'h39;
			4'hd: lit = 7'h5e;
			4'he: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~lit;                             // Board segments are active low
	endfunction

	// SW9 > SW8 > SW7 > SW1 > SW0 > address low half
	function automatic logic [15:0] expected_view(input logic [9:0] sw, input addr_t addr,
			input word_t rdata, input word_t latch);
		if (sw[9]) return rdata[31:16];
		if (sw[8]) return rdata[15:0];
		if (sw[7]) return {2'b00, addr[29:16]};
		if (sw[1]) return latch[31:16];
		if (sw[0]) return latch[15:0];
		return addr[15:0];
	endfunction

	function automatic logic [9:0] frame_bits(input byte_t data);
		return {1'b1, data, 1'b0};               // Bit 0 goes first on the line
	endfunction

	task automatic abort_run(input string reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			abort_run("word mismatch");
		end
	endtask

	task automatic check_seg(input string name, input seg_t expected, input seg_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
			abort_run("segment mismatch");
		end
	endtask

	task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			abort_run("byte mismatch");
		end
	endtask

	task automatic check_display(input string name, input logic [15:0] view);
		check_seg({name, " HEX0"}, expected_seg(view[3:0]), HEX0);
		check_seg({name, " HEX1"}, expected_seg(view[7:4]), HEX1);
		check_seg({name, " HEX2"}, expected_seg(view[11:8]), HEX2);
		check_seg({name, " HEX3"}, expected_seg(view[15:12]), HEX3);
	endtask

	// Called at edge plus drive delay, returns at the same point one cycle on
	task automatic bus_write(input addr_t addr, input word_t data, input string name);
		memaddr = addr;
		wmemdata = data;
		mem_we = 1'b1;
		@(negedge CLOCK_24);
		check_byte({name, " leds"}, byte_t'({!addr[29], 1'b0}), byte_t'(LEDG[2:1]));
		@(posedge CLOCK_24);
		#DRIVE_DELAY;
		mem_we = 1'b0;
	endtask

	task automatic bus_read(input addr_t addr, input word_t expected, input string name);
		memaddr = addr;
		mem_re = 1'b1;
		exp_q.push_back(expected);               // Compared one cycle later
		name_q.push_back(name);
		@(negedge CLOCK_24);
		check_byte({name, " leds"}, byte_t'({1'b0, !addr[29]}), byte_t'(LEDG[2:1]));
		@(posedge CLOCK_24);
		#DRIVE_DELAY;
		mem_re = 1'b0;
	endtask

	always @(posedge CLOCK_24) read_seen <= mem_re;

	// Read data is valid through the cycle after the strobe
	always @(negedge CLOCK_24) begin
		if (read_seen) begin
			if (exp_q.size() == 0) begin
				abort_run("read data returned with no read pending");
			end else begin
				check_word(name_q.pop_front(), exp_q.pop_front(), rmemdata);
			end
		end
	end

	task automatic capture_tx_frame(output logic [9:0] frame);
		for (int i = 0; i < 10; i++) begin
			repeat ((i == 0) ? BIT_CLKS / 2 : BIT_CLKS) @(negedge CLOCK_24);   // Mid bit
			frame[i] = UART_TXD;
		end
	endtask

	task automatic send_rx_frame(input byte_t data);
		logic [9:0] bits;
		bits = frame_bits(data);
		for (int i = 0; i < 10; i++) begin
			UART_RXD = bits[i];
			repeat (BIT_CLKS) @(posedge CLOCK_24);
			#DRIVE_DELAY;
		end
	endtask

	task automatic wait_tx_idle();
		int n;
		for (n = 0; n < 2 * FRAME_CYCLES; n++) begin
			@(negedge CLOCK_24);
			if (!LEDG[3]) break;                 // Busy LED mirrors tx busy
		end
		if (n == 2 * FRAME_CYCLES) begin
			abort_run("transmitter busy flag never cleared");
		end else begin
			@(posedge CLOCK_24);
			#DRIVE_DELAY;
		end
	endtask

	task automatic run_memory_test();
		addr_t a;
		word_t d;
		int k;
		for (int i = 0; i < MEM_OPS; i++) begin
			a = addr_t'(lcg_next() >> 2);
			a[29] = 1'b0;                        // Memory region
			d = lcg_next();
			bus_write(a, d, "mem write");
			shadow[a[IDX_W-1:0]] = d;
			written.push_back(a);
		end
		for (int i = 0; i < MEM_OPS; i++) begin
			k = (lcg_next() >> 16) % written.size();
			a = addr_t'(lcg_next() >> 2);        // Upper bits alias the same word
			a[29] = 1'b0;
			a[IDX_W-1:0] = written[k][IDX_W-1:0];
			bus_read(a, shadow[a[IDX_W-1:0]], "mem read");
			if (i % 8 == 0) begin
				bus_read(UNMAPPED, '0, "unmapped read");
				bus_read(DEBUG_ADDR, '0, "debug read");
			end
		end
	endtask

	task automatic run_display_test();
		word_t rd_val;
		word_t latch;
		rd_val = 32'ha5c3_17e9;
		bus_write(30'h0000_0123, rd_val, "display setup write");
		shadow[10'h123] = rd_val;
		bus_read(30'h0000_0123, rd_val, "display setup read");
		SW = 10'h003;                            // Latch still zero from reset
		@(negedge CLOCK_24);
		check_display("latch reset", expected_view(SW, memaddr, rd_val, '0));
		@(posedge CLOCK_24);
		#DRIVE_DELAY;
		latch = lcg_next();
		bus_write(DEBUG_ADDR, latch, "debug write");
		memaddr = addr_t'(lcg_next());           // No strobe, only shown
		for (int i = 0; i < 11; i++) begin
			SW = sw_list[i];
			@(negedge CLOCK_24);
			check_display($sformatf("view sw %h", SW),
				expected_view(SW, memaddr, rd_val, latch));
			@(posedge CLOCK_24);
			#DRIVE_DELAY;
		end
		SW = '0;
	endtask

	task automatic run_uart_tx_test();
		byte_t b;
		logic [9:0] frame;
		b = byte_t'(lcg_next() >> 24);
		bus_write(UART_DATA, word_t'(b), "tx write");
		fork
			capture_tx_frame(frame);
			begin
				bus_read(UART_STAT, 32'h1, "tx busy status");
				bus_write(UART_DATA, word_t'(~b), "tx write while busy");   // Must be dropped
				bus_read(UART_STAT, 32'h1, "tx busy after second write");
				@(negedge CLOCK_24);
				check_byte("tx busy led", 8'h01, byte_t'(LEDG[3]));
			end
		join
		check_word("tx frame", word_t'(frame_bits(b)), word_t'(frame));
		wait_tx_idle();
		bus_read(UART_STAT, '0, "status after frame");
		repeat (2 * BIT_CLKS) begin              // No second frame follows
			@(negedge CLOCK_24);
			check_byte("tx line idle", 8'h01, byte_t'(UART_TXD));
		end
		@(posedge CLOCK_24);
		#DRIVE_DELAY;
	endtask

	task automatic run_uart_rx_test();
		byte_t b1;
		byte_t b2;
		b1 = byte_t'(lcg_next() >> 24);
		b2 = byte_t'(lcg_next() >> 24);
		send_rx_frame(b1);
		bus_read(UART_STAT, 32'h2, "rx valid status");
		bus_read(UART_DATA, word_t'(b1), "rx data");
		bus_read(UART_STAT, '0, "rx valid cleared");
		send_rx_frame(~b2);
		send_rx_frame(b2);                       // Overwrites unread byte
		bus_read(UART_STAT, 32'h2, "rx valid after two frames");
		bus_read(UART_DATA, word_t'(b2), "rx overwrite data");
	endtask

	initial begin
		write_sync = 1'b1;
		mem_re = 1'b0;
		mem_we = 1'b0;
		memaddr = '0;
		wmemdata = '0;
		SW = '0;
		UART_RXD = 1'b1;                         // Line idle
		lcg_state = 32'd87839;
		repeat (RESET_CYCLES - 1) @(posedge CLOCK_24);
		@(negedge CLOCK_24);
		check_byte("reset leds", 8'h01, byte_t'(LEDG));
		@(posedge CLOCK_24);
		#DRIVE_DELAY;
		write_sync = 1'b0;
		check_byte("reset txd", 8'h01, byte_t'(UART_TXD));
		check_word("reset rdata", '0, rmemdata);
		bus_read(UART_STAT, '0, "reset status");
		run_memory_test();
		run_display_test();
		run_uart_tx_test();
		run_uart_rx_test();
		repeat (2) @(posedge CLOCK_24);          // Let the last compare run
		if (exp_q.size() != 0) begin
			abort_run("reads issued but never compared");
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

	initial begin
		#(2 * TEST_CYCLES * CLK_PERIOD);
		$display("Timeout after %0d cycles, tests did not complete", 2 * TEST_CYCLES);
		abort_run("watchdog timeout");
	end

endmodule

// ==== list.f ====
+incdir+design
design/soc_pkg.sv
design/cpu_bus_if.sv
design/bus_decoder.sv
design/sync_memory.sv
design/uart_port.sv
design/debug_display.sv
design/soc_top.sv
testbench/tb_soc.sv

// ==== Bender.yml ====
package:
  name: soc_periph

sources:
  - include_dirs:
      - design
    files:
      - design/soc_pkg.sv
      - design/cpu_bus_if.sv
      - design/bus_decoder.sv
      - design/sync_memory.sv
      - design/uart_port.sv
      - design/debug_display.sv
      - design/soc_top.sv
      - target: test
        files:
          - testbench/tb_soc.sv
